// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_memory_controller
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

SRCS = $(shell grep -v '^+' $(FLIST)) hw/mc_defines.svh
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_memory_controller.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module tb_memory_controller;

    import mc_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_DIRECTED = 8;            // Accesses in tests 2 to 4
    localparam int          NUM_RANDOM   = 300;
    localparam int          ACK_TIMEOUT  = 20;           // Cycles per access
    localparam int          HIT_LATENCY  = 2;
    localparam int          WATCHDOG_NS  = ((NUM_DIRECTED + NUM_RANDOM) * 10
                                            + RESET_CYCLES + 10) * CLK_PERIOD;
    localparam logic [15:0] LFSR_SEED    = 16'd15;
    localparam logic [15:0] LFSR_TAPS    = 16'hB400;     // x^16 + x^14 + x^13 + x^11 + 1

    logic                  clk;
    logic                  reset_n;
    logic                  req;
    cpu_req_t              cpu_req;
    logic                  ack;
    logic [`MC_DATA_W-1:0] rdata;

    logic [15:0] lfsr_q;
    logic [7:0]  shadow [logic [15:0]];                  // Written bytes by address
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors0;                           // Errors at test start

    memory_controller u_dut (.clk, .reset_n, .req, .cpu_req, .ack, .rdata);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[14:0], lfsr_q[0]};
        end
    endtask

    // Unwritten byte comes from word w holding the value w
    function automatic logic [7:0] expected_byte(input logic [15:0] addr);
        logic [31:0] word_val;
        if (shadow.exists(addr)) return shadow[addr];
        word_val = 32'(addr >> 2);
        return word_val[addr[1:0] * 8 +: 8];
    endfunction

    // Starts and ends at a falling edge with req and ack low
    task automatic access(input logic rw, input logic [15:0] addr,
                          input logic [7:0] wdata, output int cycles);
        logic [7:0] exp;
        cpu_req.rw    = rw;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        req           = 1'b1;
        cycles        = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < ACK_TIMEOUT);
        if (!ack) begin
            $display("%0t: no ack within %0d cycles for access to %h", $time, ACK_TIMEOUT, addr);
            errors++;
            req = 1'b0;
            @(negedge clk);
            return;
        end
        if (rw) begin
            shadow[addr] = wdata;                        // Model follows the write
        end else begin
            exp = expected_byte(addr);
            checks++;
            if (rdata !== exp) begin
                $display("CHECK FAILED at %0t: rdata = %h, expected %h (addr %h)",
                         $time, rdata, exp, addr);
                errors++;
            end
        end
        @(negedge clk);                                  // Ack must hold while req does
        checks++;
        if (ack !== 1'b1) begin
            $display("CHECK FAILED at %0t: ack = %b, expected 1 while req held", $time, ack);
            errors++;
        end
        req = 1'b0;
        @(negedge clk);
        checks++;
        if (ack !== 1'b0) begin
            $display("CHECK FAILED at %0t: ack = %b, expected 0 after req fell", $time, ack);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors0 = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors0);
        end
    endtask

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        logic [15:0] bits;
        logic        rw;
        logic [1:0]  tag;
        logic [2:0]  idx;
        logic [1:0]  off;
        logic [7:0]  wd;
        int          cyc;
        int          n;
        clk          = 1'b0;
        reset_n      = 1'b0;
        req          = 1'b0;
        cpu_req      = '0;
        lfsr_q       = LFSR_SEED;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;

        // Test 1 checks quiet outputs through reset and idle
        begin_test();
        for (n = 1; n <= RESET_CYCLES + 4; n++) begin
            @(negedge clk);
            reset_n = (n >= RESET_CYCLES);               // Released after ten rising edges
            checks++;
            if (ack !== 1'b0 || rdata !== '0) begin
                $display("CHECK FAILED at %0t: ack = %b rdata = %h, expected 0 and 00",
                         $time, ack, rdata);
                errors++;
            end
        end
        end_test("reset");

        // Test 2 reads fresh lines that refill from memory
        begin_test();
        access(1'b0, 16'h3A59, 8'h00, cyc);              // Byte 1 of word 0xE96
        access(1'b0, 16'h3A58, 8'h00, cyc);              // Byte 0 of the same line
        access(1'b0, 16'h0C13, 8'h00, cyc);
        end_test("refill read");

        // Test 3 allocates on a write and then reads back on a hit
        begin_test();
        access(1'b1, 16'h0104, 8'hA5, cyc);
        access(1'b0, 16'h0104, 8'h00, cyc);
        checks++;
        if (cyc != HIT_LATENCY) begin
            $display("CHECK FAILED at %0t: ack latency = %0d, expected %0d",
                     $time, cyc, HIT_LATENCY);
            errors++;
        end
        end_test("write hit");

        // Test 4 checks that a dirty byte survives a conflict eviction
        begin_test();
        access(1'b1, 16'h0208, 8'h5C, cyc);              // Tag 2 at index 2
        access(1'b0, 16'h0508, 8'h00, cyc);              // Tag 5 at the same index
        access(1'b0, 16'h0208, 8'h00, cyc);
        end_test("eviction");

        // Test 5 runs a random mix over 4 tags and 8 indexes
        begin_test();
        repeat (NUM_RANDOM) begin
            take_bits(1, bits);
            rw = bits[0];
            take_bits(2, bits);
            tag = bits[1:0];
            take_bits(3, bits);
            idx = bits[2:0];
            take_bits(2, bits);
            off = bits[1:0];
            take_bits(8, bits);
            wd = bits[7:0];
            access(rw, {6'd0, tag, 3'd0, idx, off}, wd, cyc);
        end
        end_test("random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/mc_pkg.sv
hw/l1_cache_array.sv
hw/main_memory.sv
hw/cache_ctrl.sv
hw/memory_controller.sv
dv/tb_memory_controller.sv

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module cache_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  req,
    input  mc_pkg::cpu_req_t      cpu_req,
    input  logic                  hit,
    input  logic [`MC_DATA_W-1:0] rd_byte,
    input  logic                  victim_dirty,
    input  logic [`MC_WORD_W-1:0] victim_word,
    output logic                  ack,
    output logic [`MC_DATA_W-1:0] rdata,
    output mc_pkg::mem_addr_u     lookup_addr,
    output logic                  fill,
    output logic                  byte_we,
    output logic [`MC_DATA_W-1:0] wdata,
    output logic                  mem_valid,
    output mc_pkg::mem_cmd_t      mem_cmd
);

    import mc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,                                            // Wait for req
        LOOKUP,                                          // Tag compare
        WRITEBACK,                                       // Dirty victim to memory
        REFILL,                                          // Memory read issued
        FILL,                                            // Line lands in L1
        ACK                                              // Hold ack until req drops
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_nx;
    cpu_req_t    req_q;                                  // Latched request

    ////////////////////////////////////////
    // Request latch
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req) begin
            req_q <= cpu_req;
        end
    end

    assign lookup_addr = req_q.addr;
    assign wdata       = req_q.wdata;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb begin
        state_nx = state_q;
        case (state_q)
            IDLE: begin
                if (req) state_nx = LOOKUP;
            end
            LOOKUP: begin
                if (hit) begin
                    state_nx = ACK;                      // Read or write done here
                end else if (victim_dirty) begin
                    state_nx = WRITEBACK;
                end else begin
                    state_nx = REFILL;
                end
            end
            WRITEBACK: state_nx = REFILL;
            REFILL:    state_nx = FILL;
            FILL:      state_nx = LOOKUP;                // Retry the lookup, which now hits
            ACK: begin
                if (!req) state_nx = IDLE;               // Four-phase release
            end
            default:   state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
            ack     <= 1'b0;
            rdata   <= '0;
        end else begin
            state_q <= state_nx;
            ack     <= (state_nx == ACK);                // Falls a cycle after req
            if (state_q == LOOKUP && hit && !req_q.rw) begin
                rdata <= rd_byte;                        // Held through ack
            end
        end
    end

    ////////////////////////////////////////
    // L1 and memory strobes
    ////////////////////////////////////////
    assign byte_we   = (state_q == LOOKUP) && hit && req_q.rw;
    assign fill      = (state_q == FILL);
    assign mem_valid = (state_q == WRITEBACK) || (state_q == REFILL);

    always_comb begin
        mem_cmd.we   = (state_q == WRITEBACK);
        // Victim's own word on write-back and the requested word on refill
        mem_cmd.word = (state_q == WRITEBACK) ? victim_word : req_q.addr.mem.word;
    end

    // Ack only answers a request still being held
    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(ack) |-> req
    );

    // Retried lookup after a fill must find the new line
    a_hit_after_fill : assert property (
        @(posedge clk) disable iff (!reset_n)
        fill |=> hit
    );

endmodule

// ==== hw/l1_cache_array.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module l1_cache_array (
    input  logic                  clk,
    input  logic                  reset_n,
    input  mc_pkg::mem_addr_u     lookup_addr,           // Held for the whole access
    input  logic                  fill,                  // Load line from memory
    input  logic [`MC_LINE_W-1:0] fill_line,
    input  logic                  byte_we,               // Merge one byte
    input  logic [`MC_DATA_W-1:0] wdata,
    output logic                  hit,
    output logic [`MC_DATA_W-1:0] rd_byte,
    output logic                  victim_dirty,
    output logic [`MC_WORD_W-1:0] victim_word,
    output logic [`MC_LINE_W-1:0] victim_line
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    logic [`MC_LINE_W-1:0]   data_mem [`MC_L1_LINES];    // Line payload
    logic [`MC_TAG_W-1:0]    tag_mem  [`MC_L1_LINES];
    logic [`MC_L1_LINES-1:0] valid_q;                    // Cleared by reset
    logic [`MC_L1_LINES-1:0] dirty_q;

    logic [`MC_INDEX_W-1:0]  idx;
    logic [`MC_LINE_W-1:0]   line;                       // Line at the index
    logic [`MC_TAG_W-1:0]    line_tag;

    assign idx      = lookup_addr.cache.index;
    assign line     = data_mem[idx];
    assign line_tag = tag_mem[idx];

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////
    assign hit     = valid_q[idx] && (line_tag == lookup_addr.cache.tag);
    assign rd_byte = line[lookup_addr.cache.offset * `MC_DATA_W +: `MC_DATA_W];

    // Victim is whatever sits at the index now
    assign victim_dirty = valid_q[idx] && dirty_q[idx];
    assign victim_word  = {line_tag, idx};               // Rebuilt word index
    assign victim_line  = line;

    ////////////////////////////////////////
    // Payload and tag writes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[idx] <= fill_line;                  // Whole line from memory
            tag_mem[idx]  <= lookup_addr.cache.tag;
        end else if (byte_we) begin
            // Only the addressed lane changes
            data_mem[idx][lookup_addr.cache.offset * `MC_DATA_W +: `MC_DATA_W] <= wdata;
        end
    end

    ////////////////////////////////////////
    // Valid and dirty state
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;                               // Cache starts empty
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;                        // Fresh copy of memory
        end else if (byte_we) begin
            dirty_q[idx] <= 1'b1;                        // Needs write-back on eviction
        end
    end

    // Writes are merged only into a resident line, refill comes first
    a_we_on_hit : assert property (
        @(posedge clk) disable iff (!reset_n)
        byte_we |-> hit
    );

endmodule

// ==== hw/main_memory.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module main_memory (
    input  logic                  clk,
    input  logic                  mem_valid,
    input  mc_pkg::mem_cmd_t      mem_cmd,
    input  logic [`MC_LINE_W-1:0] wr_line,               // Victim line from L1
    output logic [`MC_LINE_W-1:0] mem_rdata
);

    logic [`MC_LINE_W-1:0] mem [`MC_MEM_WORDS];

    ////////////////////////////////////////
    // Initial contents
    ////////////////////////////////////////
    // Word w holds the value w
    initial begin
        for (int i = 0; i < `MC_MEM_WORDS; i++) begin
            mem[i] = `MC_LINE_W'(i);
        end
    end

    ////////////////////////////////////////
    // Access
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            if (mem_cmd.we) begin
                mem[mem_cmd.word] <= wr_line;            // Write-back
            end else begin
                mem_rdata <= mem[mem_cmd.word];          // Refill data, one cycle later
            end
        end
    end

    // Controller must present a resolved word with every command
    a_word_known : assert property (
        @(posedge clk)
        mem_valid |-> !$isunknown(mem_cmd.word)
    );

endmodule

// ==== hw/mc_defines.svh ====
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

////////////////////////////////////////
// Processor side
////////////////////////////////////////
`define MC_ADDR_W     16                                 // Byte address
`define MC_DATA_W     8                                  // One byte per access

////////////////////////////////////////
// L1 geometry
////////////////////////////////////////
`define MC_LINE_W     32                                 // One word per line
`define MC_OFFSET_W   2                                  // Byte within the word
`define MC_INDEX_W    6
`define MC_L1_LINES   64                                 // 2**MC_INDEX_W
`define MC_TAG_W      (`MC_ADDR_W - `MC_INDEX_W - `MC_OFFSET_W)

////////////////////////////////////////
// Main memory geometry
////////////////////////////////////////
// Tag and index together make up the word index
`define MC_WORD_W     (`MC_ADDR_W - `MC_OFFSET_W)
`define MC_MEM_WORDS  (1 << `MC_WORD_W)                  // 16384 words

`endif

// ==== hw/mc_pkg.sv ====
`include "mc_defines.svh"

package mc_pkg;

    ////////////////////////////////////////
    // Address views
    ////////////////////////////////////////

    // Cache view of a byte address
    typedef struct packed {
        logic [`MC_TAG_W-1:0]    tag;
        logic [`MC_INDEX_W-1:0]  index;                  // Selects the L1 line
        logic [`MC_OFFSET_W-1:0] offset;                 // Byte lane
    } mem_addr_t;

    // Memory view, same bits
    typedef struct packed {
        logic [`MC_WORD_W-1:0]   word;                   // Main memory word index
        logic [`MC_OFFSET_W-1:0] offset;
    } word_addr_t;

    typedef union packed {
        mem_addr_t  cache;
        word_addr_t mem;
    } mem_addr_u;

    ////////////////////////////////////////
    // Transfers
    ////////////////////////////////////////

    // Processor request, stable while req is high
    typedef struct packed {
        logic                  rw;                       // 1 = write
        mem_addr_u             addr;
        logic [`MC_DATA_W-1:0] wdata;
    } cpu_req_t;

    // Main memory command, line data travels on its own wire
    typedef struct packed {
        logic                  we;
        logic [`MC_WORD_W-1:0] word;
    } mem_cmd_t;

endpackage

// ==== hw/memory_controller.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module memory_controller (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  req,
    input  mc_pkg::cpu_req_t      cpu_req,
    output logic                  ack,
    output logic [`MC_DATA_W-1:0] rdata
);

    import mc_pkg::*;

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////
    mem_addr_u             lookup_addr;                  // Latched request address
    logic                  fill;
    logic                  byte_we;
    logic [`MC_DATA_W-1:0] wdata;
    logic                  hit;
    logic [`MC_DATA_W-1:0] rd_byte;
    logic                  victim_dirty;
    logic [`MC_WORD_W-1:0] victim_word;
    logic [`MC_LINE_W-1:0] victim_line;                  // Write-back data
    logic                  mem_valid;
    mem_cmd_t              mem_cmd;
    logic [`MC_LINE_W-1:0] mem_rdata;                    // Refill data

    cache_ctrl u_ctrl (
        .clk, .reset_n, .req, .cpu_req,
        .hit, .rd_byte, .victim_dirty, .victim_word,
        .ack, .rdata, .lookup_addr, .fill, .byte_we, .wdata,
        .mem_valid, .mem_cmd
    );

    l1_cache_array u_l1 (
        .clk, .reset_n, .lookup_addr, .fill,
        .fill_line (mem_rdata),
        .byte_we, .wdata,
        .hit, .rd_byte, .victim_dirty, .victim_word, .victim_line
    );

    main_memory u_mem (
        .clk, .mem_valid, .mem_cmd,
        .wr_line   (victim_line),
        .mem_rdata
    );

endmodule
